// File: design/bp_pkg.sv
package bp_pkg;

    // ----------------------------------------
    // widths and counts
    // ----------------------------------------

    // angles are whole degrees 0 to 179
    localparam int k_angle_length = 8;
    localparam int k_angle_max = 179;
    // filtered samples and RAM addresses are signed
    localparam int k_data_length = 12;
    localparam int k_s_length = 10;
    // taps per line and lines per angle
    localparam int k_no_of_partitions = 4;
    localparam int k_partition_size = 4;
    localparam int k_shift_cycles = 8;

    // scan decode thresholds
    localparam int k_angle_45 = 45;
    localparam int k_angle_90 = 90;
    localparam int k_angle_135 = 135;

    // counter widths
    localparam int k_line_itr_length = $clog2(k_partition_size);
    // one extra count for the last capture cycle
    localparam int k_tap_cnt_length = $clog2(k_no_of_partitions + 1);
    localparam int k_shift_cnt_length = $clog2(k_shift_cycles);

    // ----------------------------------------
    // angle table rules
    // ----------------------------------------

    // mp_accu_part = 400 - angle
    localparam logic signed [k_s_length-1:0] k_mp_accu_part_top = 400;
    // mp_accu_base = 3 + (angle mod 4)
    localparam logic signed [k_s_length-1:0] k_mp_accu_base_min = 3;
    // sh_accu_base = 16 + (angle mod 8)
    localparam logic signed [k_s_length-1:0] k_sh_accu_base_min = 16;

    // ----------------------------------------
    // state and mode encodings
    // ----------------------------------------

    typedef enum logic [3:0] {
        ready, setup_1, setup_2, setup_3, fill, fill_and_shift,
        angle_setup_1, angle_setup_2, angle_setup_3, shift
    } ctrl_state_t;

    typedef enum logic [1:0] {idle, filling, full, shifting} sw_state_t;

    typedef enum logic {scan_x, scan_y} scan_mode_t;
    typedef enum logic {forward, reverse} scan_dir_t;

endpackage

// File: design/swap_if.sv
`timescale 1ns/100ps

interface swap_if;
    import bp_pkg::*;

    // control to swappable
    logic next_itr_ack;
    logic swap_ack;
    logic signed [k_s_length-1:0] mp_accu_init;
    logic signed [k_s_length-1:0] sh_accu_base;
    // swappable to control
    logic next_itr;
    logic swap;
    // swappable to the PE side
    logic pe_en;
    logic [k_data_length*k_no_of_partitions-1:0] taps;

    modport control
    (
        output next_itr_ack, swap_ack, mp_accu_init, sh_accu_base,
        input next_itr, swap
    );

    modport buffer
    (
        input next_itr_ack, swap_ack, mp_accu_init, sh_accu_base,
        output next_itr, swap, pe_en, taps
    );

    // output side only watches the shift
    modport monitor
    (
        input pe_en, taps
    );

endinterface

// File: design/angle_lut.sv
`timescale 1ns/100ps

module angle_lut
(
    input  logic clk,
    input  logic reset_n,
    input  logic [bp_pkg::k_angle_length-1:0] angle,
    output logic signed [bp_pkg::k_s_length-1:0] mp_accu_part,
    output logic signed [bp_pkg::k_s_length-1:0] mp_accu_base,
    output logic signed [bp_pkg::k_s_length-1:0] sh_accu_base
);
    import bp_pkg::*;

    // stage one registers
    logic [k_angle_length-1:0] angle_q;
    logic [1:0] angle_mod4;
    logic [2:0] angle_mod8;

    // ----------------------------------------
    // stage one
    // ----------------------------------------

    // angle and its residues
    always_ff @(posedge clk)
    begin
        angle_q <= angle;
        angle_mod4 <= angle[1:0];
        angle_mod8 <= angle[2:0];
    end

    // ----------------------------------------
    // stage two
    // ----------------------------------------

    // table outputs, two cycles after the angle moves
    always_ff @(posedge clk)
    begin
        mp_accu_part <= k_mp_accu_part_top - $signed(k_s_length'(angle_q));
        mp_accu_base <= k_mp_accu_base_min + $signed(k_s_length'(angle_mod4));
        sh_accu_base <= k_sh_accu_base_min + $signed(k_s_length'(angle_mod8));
    end

    // the angle source only hands out whole degrees below 180
    a_angle_range: assert property (@(posedge clk) disable iff (!reset_n)
        angle <= k_angle_max)
        else $error("[ERROR] angle %0d out of range", angle);

endmodule

// File: design/line_swappable.sv
`timescale 1ns/100ps

module line_swappable
(
    input  logic clk,
    input  logic reset_n,
    swap_if.buffer sw,
    input  logic signed [bp_pkg::k_data_length-1:0] fr_val,
    output logic signed [bp_pkg::k_s_length-1:0] fr_s_val
);
    import bp_pkg::*;

    sw_state_t state;
    // tap index of the address on fr_s_val
    logic [k_tap_cnt_length-1:0] tap_cnt;
    logic [k_shift_cnt_length-1:0] shift_cnt;
    // next address of the fill
    logic signed [k_s_length-1:0] run_addr;
    logic [k_no_of_partitions-1:0][k_data_length-1:0] taps_q;
    logic last_capture;
    logic last_shift;

    // count N is the cycle that only captures
    assign last_capture = (tap_cnt == k_tap_cnt_length'(k_no_of_partitions));
    assign last_shift = (shift_cnt == k_shift_cnt_length'(k_shift_cycles - 1));

    // ----------------------------------------
    // state machine
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= idle;
            tap_cnt <= '0;
            shift_cnt <= '0;
        end
        else
        begin
            case (state)
                idle:
                    if (sw.next_itr_ack)
                    begin
                        state <= filling;
                        tap_cnt <= '0;
                    end
                filling:
                    if (last_capture)
                        state <= full;
                    else
                        tap_cnt <= tap_cnt + 1'b1;
                full:
                    // hold the taps until control kicks the PEs
                    if (sw.swap_ack)
                    begin
                        state <= shifting;
                        shift_cnt <= '0;
                    end
                shifting:
                begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (last_shift)
                        state <= idle;
                end
                default:
                    state <= idle;
            endcase
        end
    end

    // ----------------------------------------
    // fill addresses and tap capture
    // ----------------------------------------

    // first address comes straight from control, the rest step by sh_accu_base
    assign fr_s_val = (tap_cnt == '0) ? sw.mp_accu_init : run_addr;

    always_ff @(posedge clk)
    begin
        if (state == filling)
            run_addr <= fr_s_val + sw.sh_accu_base;
    end

    // RAM data lags its address by one cycle
    always_ff @(posedge clk)
    begin
        if (state == filling && tap_cnt != '0)
            taps_q <= {fr_val, taps_q[k_no_of_partitions-1:1]};
    end

    // handshake levels
    assign sw.next_itr = (state == idle);
    assign sw.swap = (state == full);
    assign sw.pe_en = (state == shifting);
    assign sw.taps = taps_q;

    a_swap_itr_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(sw.swap && sw.next_itr));

    // control may only kick a full line
    a_swap_ack_full: assert property (@(posedge clk) disable iff (!reset_n)
        sw.swap_ack |-> state == full);

    a_itr_ack_idle: assert property (@(posedge clk) disable iff (!reset_n)
        sw.next_itr_ack |-> state == idle);

endmodule

// File: design/swap_control.sv
`timescale 1ns/100ps

module swap_control
(
    input  logic clk,
    input  logic reset_n,
    // angle source
    input  logic [bp_pkg::k_angle_length-1:0] fr_angle,
    input  logic fr_has_next_angle,
    input  logic fr_next_angle_ack,
    output logic fr_next_angle,
    // table values
    input  logic signed [bp_pkg::k_s_length-1:0] mp_accu_part,
    input  logic signed [bp_pkg::k_s_length-1:0] mp_accu_base,
    input  logic signed [bp_pkg::k_s_length-1:0] sh_accu_base,
    // swappables
    swap_if.control sw0,
    swap_if.control sw1,
    // output side
    output logic sw_sel,
    output logic [bp_pkg::k_angle_length-1:0] kick_angle,
    output logic pe_reset,
    output logic pe_kick
);
    import bp_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    // index of the line being filled in swa
    logic [k_line_itr_length-1:0] line_itr;
    logic has_next_line;
    logic signed [k_s_length-1:0] mp_accu_init;
    // angle of the line being filled in swa
    logic [k_angle_length-1:0] fill_angle;
    // swa fills, swb shifts
    logic swa_swap;
    logic swb_next_itr;
    logic swa_next_itr_ack;
    logic swb_next_itr_ack;
    logic swap_ack;
    logic lines_ready;

    // ----------------------------------------
    // role mapping by sw_sel
    // ----------------------------------------

    // sw_sel 0 means sw0 fills and sw1 shifts
    assign swa_swap = sw_sel ? sw1.swap : sw0.swap;
    assign swb_next_itr = sw_sel ? sw0.next_itr : sw1.next_itr;
    assign sw0.next_itr_ack = sw_sel ? swb_next_itr_ack : swa_next_itr_ack;
    assign sw1.next_itr_ack = sw_sel ? swa_next_itr_ack : swb_next_itr_ack;
    assign sw0.swap_ack = !sw_sel && swap_ack;
    assign sw1.swap_ack = sw_sel && swap_ack;
    assign sw0.mp_accu_init = mp_accu_init;
    assign sw1.mp_accu_init = mp_accu_init;
    assign sw0.sh_accu_base = sh_accu_base;
    assign sw1.sh_accu_base = sh_accu_base;

    // ----------------------------------------
    // Mealy outputs
    // ----------------------------------------

    assign has_next_line = (line_itr != k_line_itr_length'(k_partition_size - 1));
    // swa has a full line and swb is done shifting
    assign lines_ready = (state == fill || state == fill_and_shift) &&
                         swa_swap && swb_next_itr;

    // first line of a run
    assign swa_next_itr_ack = (state == setup_3);
    // the angle bubble swaps once the new constants are loaded
    assign swap_ack = (state == angle_setup_3) ||
                      (lines_ready && (has_next_line || !fr_has_next_angle));
    // after the last line of the last angle nothing more gets filled
    assign swb_next_itr_ack = (state == angle_setup_3) ||
                              (lines_ready && has_next_line);
    // ask only when no ack can be lost
    assign fr_next_angle = fr_has_next_angle &&
                           ((state == ready) || (lines_ready && !has_next_line));

    assign pe_reset = swa_next_itr_ack;
    assign pe_kick = swap_ack;
    assign kick_angle = fill_angle;

    // ----------------------------------------
    // next state
    // ----------------------------------------

    always_comb
    begin
        next_state = state;
        case (state)
            ready:
                if (fr_next_angle_ack)
                    next_state = setup_1;
            // two cycles of table latency
            setup_1:
                next_state = setup_2;
            setup_2:
                next_state = setup_3;
            setup_3:
                next_state = fill;
            fill, fill_and_shift:
                if (lines_ready)
                begin
                    if (has_next_line)
                        next_state = fill_and_shift;
                    else if (!fr_has_next_angle)
                        next_state = shift;
                    else if (fr_next_angle_ack)
                        next_state = angle_setup_1;
                end
            angle_setup_1:
                next_state = angle_setup_2;
            angle_setup_2:
                next_state = angle_setup_3;
            angle_setup_3:
                next_state = fill_and_shift;
            // last line drains out of swb
            shift:
                if (swb_next_itr)
                    next_state = ready;
            default:
                next_state = ready;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready;
            sw_sel <= 1'b0;
            line_itr <= '0;
        end
        else
        begin
            state <= next_state;
            if (swap_ack)
                sw_sel <= !sw_sel;
            if (state == ready || state == angle_setup_3)
                line_itr <= '0;
            else if (swap_ack)
                line_itr <= line_itr + 1'b1;
        end
    end

    // line start accumulator, read by the buffer one cycle after its ack
    always_ff @(posedge clk)
    begin
        if (state == setup_3 || state == angle_setup_3)
            mp_accu_init <= mp_accu_part;
        else if (swap_ack)
            mp_accu_init <= mp_accu_init - mp_accu_base;
        if (swa_next_itr_ack || swb_next_itr_ack)
            fill_angle <= fr_angle;
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
        state inside {ready, setup_1, setup_2, setup_3, fill, fill_and_shift,
                      angle_setup_1, angle_setup_2, angle_setup_3, shift});

    // the source never acks an angle that was not asked for
    a_ack_requested: assert property (@(posedge clk) disable iff (!reset_n)
        fr_next_angle_ack |-> fr_next_angle);

endmodule

// File: design/pe_control.sv
`timescale 1ns/100ps

module pe_control
(
    input  logic clk,
    input  logic reset_n,
    input  logic sw_sel,
    input  logic pe_kick,
    input  logic [bp_pkg::k_angle_length-1:0] kick_angle,
    swap_if.monitor sw0,
    swap_if.monitor sw1,
    output logic pe_en,
    output logic [bp_pkg::k_data_length*bp_pkg::k_no_of_partitions-1:0] pe_taps,
    output bp_pkg::scan_mode_t pe_scan_mode,
    output bp_pkg::scan_dir_t pe_scan_direction
);
    import bp_pkg::*;

    // the shifting buffer is the one not being filled
    assign pe_en = sw_sel ? sw0.pe_en : sw1.pe_en;
    assign pe_taps = sw_sel ? sw0.taps : sw1.taps;

    // ----------------------------------------
    // angle decode
    // ----------------------------------------

    // decoded for the kicked line, valid from the next cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pe_scan_mode <= scan_x;
            pe_scan_direction <= forward;
        end
        else if (pe_kick)
        begin
            pe_scan_mode <= (kick_angle < k_angle_45 || kick_angle >= k_angle_135) ?
                            scan_x : scan_y;
            pe_scan_direction <= (kick_angle < k_angle_90) ? forward : reverse;
        end
    end

    // a kick always starts the shift on the next cycle
    a_kick_shift: assert property (@(posedge clk) disable iff (!reset_n)
        pe_kick |=> pe_en);

endmodule

// File: design/bp_processing_top.sv
`timescale 1ns/100ps

module bp_processing_top
(
    input  logic clk,
    input  logic reset_n,
    // angle source
    input  logic [bp_pkg::k_angle_length-1:0] fr_angle,
    input  logic fr_has_next_angle,
    input  logic fr_next_angle_ack,
    output logic fr_next_angle,
    // RAM banks
    input  logic signed [bp_pkg::k_data_length-1:0] fr0_val,
    input  logic signed [bp_pkg::k_data_length-1:0] fr1_val,
    output logic signed [bp_pkg::k_s_length-1:0] fr0_s_val,
    output logic signed [bp_pkg::k_s_length-1:0] fr1_s_val,
    // processing elements
    output logic pe_reset,
    output logic pe_kick,
    output logic pe_en,
    output logic [bp_pkg::k_data_length*bp_pkg::k_no_of_partitions-1:0] pe_taps,
    output bp_pkg::scan_mode_t pe_scan_mode,
    output bp_pkg::scan_dir_t pe_scan_direction
);
    import bp_pkg::*;

    logic signed [k_s_length-1:0] mp_accu_part;
    logic signed [k_s_length-1:0] mp_accu_base;
    logic signed [k_s_length-1:0] sh_accu_base;
    logic sw_sel;
    logic [k_angle_length-1:0] kick_angle;

    swap_if sw0_if ();
    swap_if sw1_if ();

    angle_lut angle_lut_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .angle(fr_angle),
        .mp_accu_part(mp_accu_part),
        .mp_accu_base(mp_accu_base),
        .sh_accu_base(sh_accu_base)
    );

    swap_control swap_control_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .fr_angle(fr_angle),
        .fr_has_next_angle(fr_has_next_angle),
        .fr_next_angle_ack(fr_next_angle_ack),
        .fr_next_angle(fr_next_angle),
        .mp_accu_part(mp_accu_part),
        .mp_accu_base(mp_accu_base),
        .sh_accu_base(sh_accu_base),
        .sw0(sw0_if.control),
        .sw1(sw1_if.control),
        .sw_sel(sw_sel),
        .kick_angle(kick_angle),
        .pe_reset(pe_reset),
        .pe_kick(pe_kick)
    );

    // one swappable per RAM bank
    line_swappable sw0_buf
    (
        .clk(clk),
        .reset_n(reset_n),
        .sw(sw0_if.buffer),
        .fr_val(fr0_val),
        .fr_s_val(fr0_s_val)
    );

    line_swappable sw1_buf
    (
        .clk(clk),
        .reset_n(reset_n),
        .sw(sw1_if.buffer),
        .fr_val(fr1_val),
        .fr_s_val(fr1_s_val)
    );

    pe_control pe_control_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .sw_sel(sw_sel),
        .pe_kick(pe_kick),
        .kick_angle(kick_angle),
        .sw0(sw0_if.monitor),
        .sw1(sw1_if.monitor),
        .pe_en(pe_en),
        .pe_taps(pe_taps),
        .pe_scan_mode(pe_scan_mode),
        .pe_scan_direction(pe_scan_direction)
    );

endmodule

// File: test/tb_bp_processing.sv
`timescale 1ns/100ps

module tb_bp_processing;
    import bp_pkg::*;

    localparam int num_angles = 5;
    localparam int total_lines = num_angles * k_partition_size;
    localparam int wait_limit = 600;

    logic clk;
    logic reset_n;
    logic [k_angle_length-1:0] fr_angle;
    logic fr_has_next_angle;
    logic fr_next_angle_ack;
    logic fr_next_angle;
    logic signed [k_data_length-1:0] fr0_val = '0;
    logic signed [k_data_length-1:0] fr1_val = '0;
    logic signed [k_s_length-1:0] fr0_s_val;
    logic signed [k_s_length-1:0] fr1_s_val;
    logic pe_reset;
    logic pe_kick;
    logic pe_en;
    logic [k_data_length*k_no_of_partitions-1:0] pe_taps;
    scan_mode_t pe_scan_mode;
    scan_dir_t pe_scan_direction;

    // angle source
    int angle_list [num_angles];
    int angles_sent = 0;
    int seed;
    int wait_cnt;
    // scoreboard, updated on the falling edge
    int cycle = 0;
    int kicks = 0;
    int resets = 0;
    int last_kicked = -1;
    int shift_left = 0;
    int fill_line = 0;
    int fill_tap = k_no_of_partitions;
    int bank_addr;
    int cur_angle;
    string bank_name;
    // RAM bank read addresses
    int ram_addr0;
    int ram_addr1;
    // address, taps, decode, sequence
    int err_cnt [4] = '{default: 0};

    bp_processing_top bp_processing_top_i (.*);

    always #10 clk = !clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // ----------------------------------------
    // reference rules
    // ----------------------------------------

    // line start steps down by 3 + a mod 4, taps step up by 16 + a mod 8
    function automatic int line_addr(input int line, input int tap);
        int a;
        a = angle_list[line / k_partition_size];
        return (400 - a) - (line % k_partition_size) * (3 + a % 4) + tap * (16 + a % 8);
    endfunction

    // bank contents mix the whole address with the bank number
    function automatic int bank_value(input int addr, input int bank);
        logic signed [k_data_length-1:0] v;
        v = k_data_length'(addr * 37 + bank * 1111 + 5);
        return int'(v);
    endfunction

    task automatic check_equal(input int cat, input string name, input int actual,
                               input int expected);
        assert (actual == expected)
        else
        begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, expected, actual);
            err_cnt[cat]++;
        end
    endtask

    task automatic check_true(input int cat, input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("error at %0t: %s", $time, what);
            err_cnt[cat]++;
        end
    endtask

    task automatic print_counts;
        $display("errors: address %0d, taps %0d, decode %0d, sequence %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        print_counts();
        $display("TEST FAIL");
        $finish;
    endtask

    // ----------------------------------------
    // RAM bank models
    // ----------------------------------------

    // registered read, data one cycle after the address
    always @(negedge clk)
    begin
        ram_addr0 = int'(fr0_s_val);
        ram_addr1 = int'(fr1_s_val);
    end

    always @(posedge clk)
    begin
        #2;
        fr0_val = k_data_length'(bank_value(ram_addr0, 0));
        fr1_val = k_data_length'(bank_value(ram_addr1, 1));
    end

    // ----------------------------------------
    // monitor
    // ----------------------------------------

    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            // quiet outputs once the first edge has loaded the reset
            if (cycle > 0)
            begin
                check_equal(3, "fr_next_angle", fr_next_angle, 0);
                check_equal(3, "pe_kick", pe_kick, 0);
                check_equal(3, "pe_reset", pe_reset, 0);
                check_equal(3, "pe_en", pe_en, 0);
            end
        end
        else
        begin
            // fill addresses, line n always lands on bank n mod 2
            if (fill_tap < k_no_of_partitions)
            begin
                if (fill_line % 2 == 0)
                begin
                    bank_addr = int'(fr0_s_val);
                    bank_name = "fr0_s_val";
                end
                else
                begin
                    bank_addr = int'(fr1_s_val);
                    bank_name = "fr1_s_val";
                end
                check_equal(0, bank_name, bank_addr, line_addr(fill_line, fill_tap));
                fill_tap++;
            end
            // eight shift cycles per kick, taps hold the kicked line
            check_equal(3, "pe_en", pe_en, shift_left != 0);
            if (shift_left != 0)
            begin
                for (int t = 0; t < k_no_of_partitions; t++)
                    check_equal(1, $sformatf("pe_taps[%0d]", t),
                                $signed(pe_taps[k_data_length*t +: k_data_length]),
                                bank_value(line_addr(last_kicked, t), last_kicked % 2));
                shift_left--;
            end
            // decode of the last kicked line
            if (last_kicked >= 0)
            begin
                cur_angle = angle_list[last_kicked / k_partition_size];
                check_equal(2, "pe_scan_mode", int'(pe_scan_mode),
                            (cur_angle < 45 || cur_angle >= 135) ?
                            int'(scan_x) : int'(scan_y));
                check_equal(2, "pe_scan_direction", int'(pe_scan_direction),
                            (cur_angle < 90) ? int'(forward) : int'(reverse));
            end
            // run start fills line 0 on bank 0
            if (pe_reset)
            begin
                check_true(3, resets == 0, "pe_reset pulsed more than once");
                resets++;
                fill_line = 0;
                fill_tap = 0;
            end
            // each kick but the last starts the next fill
            if (pe_kick)
            begin
                check_true(3, kicks < total_lines, "pe_kick pulsed after the last line");
                if (kicks < total_lines)
                begin
                    last_kicked = kicks;
                    shift_left = k_shift_cycles;
                end
                kicks++;
                if (kicks < total_lines)
                begin
                    fill_line = kicks;
                    fill_tap = 0;
                end
            end
            if (angles_sent == num_angles)
                check_true(3, !fr_next_angle, "angle requested after the last angle");
        end
    end

    // ----------------------------------------
    // angle source and run control
    // ----------------------------------------

    initial
    begin
        seed = 32'h7223;
        clk = 1'b0;
        reset_n = 1'b0;
        fr_angle = '0;
        fr_has_next_angle = 1'b0;
        fr_next_angle_ack = 1'b0;
        angle_list = '{10, 60, 100, 170, 0};
        angle_list[4] = {$random(seed)} % 180;

        repeat (8) @(posedge clk);
        #2;
        reset_n = 1'b1;
        fr_has_next_angle = 1'b1;

        for (int i = 0; i < num_angles; i++)
        begin
            wait_cnt = 0;
            do
            begin
                @(negedge clk);
                wait_cnt++;
            end
            while (!fr_next_angle && wait_cnt < wait_limit);
            if (!fr_next_angle)
                stop_on_timeout("an angle request");
            // ack one to three cycles later, angle moves with it
            repeat (1 + {$random(seed)} % 3) @(posedge clk);
            #2;
            fr_angle = k_angle_length'(angle_list[i]);
            fr_next_angle_ack = 1'b1;
            @(posedge clk);
            #2;
            fr_next_angle_ack = 1'b0;
            angles_sent++;
            if (i == num_angles - 1)
                fr_has_next_angle = 1'b0;
        end

        wait_cnt = 0;
        do
        begin
            @(posedge clk);
            wait_cnt++;
        end
        while (kicks < total_lines && wait_cnt < wait_limit);
        if (kicks < total_lines)
            stop_on_timeout("the last pe_kick");

        wait_cnt = 0;
        do
        begin
            @(posedge clk);
            wait_cnt++;
        end
        while (shift_left != 0 && wait_cnt < wait_limit);
        if (shift_left != 0)
            stop_on_timeout("the last shift");

        // idle window, the monitor flags any late request, kick or shift
        repeat (20) @(posedge clk);
        check_equal(3, "pe_kick count", kicks, total_lines);
        check_equal(3, "pe_reset count", resets, 1);
        print_counts();
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: vlog.f
design/bp_pkg.sv
design/swap_if.sv
design/angle_lut.sv
design/line_swappable.sv
design/swap_control.sv
design/pe_control.sv
design/bp_processing_top.sv
test/tb_bp_processing.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bp_processing \
    -f vlog.f -o tb_bp_processing > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_bp_processing > sim.log 2>&1 ; cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
